//--- hdl/lockstep_pkg.sv
// Shared types, register map and checksum step for the lockstep checksum peripheral
// Imported by the checksum units, the delay line, the comparator and the top level

package lockstep_pkg;

  localparam int DataW = 32;
  localparam int AdrW  = 1;
  localparam int CntW  = 16;

  // Bus word, also the width of the checksum
  typedef logic [DataW-1:0] wb_data_t;
  // Word address, two registers
  typedef logic [AdrW-1:0]  wb_adr_t;
  // Number of words folded into the checksum
  typedef logic [CntW-1:0]  cnt_t;

  // Register map
  localparam wb_adr_t AdrSum   = 1'b0;
  localparam wb_adr_t AdrCount = 1'b1;

  // Rotate left by one, then fold in the new word
  function automatic wb_data_t checksum_step(wb_data_t sum, wb_data_t word);
    return {sum[DataW-2:0], sum[DataW-1]} ^ word;
  endfunction

endpackage

//--- hdl/checksum_unit.sv
// Wishbone classic slave holding a rotating-XOR checksum and a word count
// Instantiated twice in the lockstep top, once as main and once as shadow

module checksum_unit import lockstep_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     wb_cyc_i,
  input  logic     wb_stb_i,
  input  logic     wb_we_i,
  input  wb_adr_t  wb_adr_i,
  input  wb_data_t wb_dat_i,
  output wb_data_t wb_dat_o,
  output logic     wb_ack_o
);

  logic     ack_q;
  logic     access;
  wb_data_t sum_d, sum_q;
  cnt_t     cnt_d, cnt_q;
  wb_data_t rdata_d, rdata_q;

  // New access only while ack is low, so each cycle gets one ack
  assign access = wb_cyc_i & wb_stb_i & ~ack_q;

  ////////////////////
  // Register update
  ////////////////////

  always_comb begin
    sum_d = sum_q;
    cnt_d = cnt_q;
    if (wb_we_i) begin
      if (wb_adr_i == AdrSum) begin
        sum_d = checksum_step(sum_q, wb_dat_i);
        cnt_d = cnt_q + cnt_t'(1);
      end else begin
        // Clear both on a count write
        sum_d = '0;
        cnt_d = '0;
      end
    end
  end

  // Addressed register after the update, count zero-extended
  assign rdata_d = (wb_adr_i == AdrSum) ? sum_d : wb_data_t'(cnt_d);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      sum_q   <= '0;
      cnt_q   <= '0;
      rdata_q <= '0;
    end else begin
      ack_q <= access;
      if (access) begin
        sum_q   <= sum_d;
        cnt_q   <= cnt_d;
        rdata_q <= rdata_d;
      end
    end
  end

  ////////////////////
  // Bus outputs
  ////////////////////

  // Data stays on the bus after ack, so state changes are visible to the comparator
  assign wb_dat_o = rdata_q;
  assign wb_ack_o = ack_q;

endmodule

//--- hdl/input_delay.sv
// Delays the master's bus signals toward the shadow unit by LockstepOffset cycles
// Also carries the fault-inject strobe, which flips bit 0 of the shadow's write data

module input_delay import lockstep_pkg::*; #(
  parameter int LockstepOffset = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     wb_cyc_i,
  input  logic     wb_stb_i,
  input  logic     wb_we_i,
  input  wb_adr_t  wb_adr_i,
  input  wb_data_t wb_dat_i,
  input  logic     inject_fault_i,
  output logic     dly_cyc_o,
  output logic     dly_stb_o,
  output logic     dly_we_o,
  output wb_adr_t  dly_adr_o,
  output wb_data_t dly_dat_o
);

  localparam int Last = LockstepOffset - 1;

  // Stage 0 takes the inputs, the last stage feeds the shadow
  logic [LockstepOffset-1:0] cyc_q, stb_q, we_q, inj_q;
  wb_adr_t  [LockstepOffset-1:0] adr_q;
  wb_data_t [LockstepOffset-1:0] dat_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc_q <= '0;
      stb_q <= '0;
      we_q  <= '0;
      inj_q <= '0;
      adr_q <= '0;
      dat_q <= '0;
    end else begin
      cyc_q <= {cyc_q[LockstepOffset-2:0], wb_cyc_i};
      stb_q <= {stb_q[LockstepOffset-2:0], wb_stb_i};
      we_q  <= {we_q[LockstepOffset-2:0], wb_we_i};
      inj_q <= {inj_q[LockstepOffset-2:0], inject_fault_i};
      adr_q <= {adr_q[LockstepOffset-2:0], wb_adr_i};
      dat_q <= {dat_q[LockstepOffset-2:0], wb_dat_i};
    end
  end

  assign dly_cyc_o = cyc_q[Last];
  assign dly_stb_o = stb_q[Last];
  assign dly_we_o  = we_q[Last];
  assign dly_adr_o = adr_q[Last];
  // Corrupt only the shadow's copy of the data
  assign dly_dat_o = dat_q[Last] ^ wb_data_t'(inj_q[Last]);

endmodule

//--- hdl/shadow_reset_gen.sv
// Holds the shadow unit in reset for LockstepOffset cycles after the main reset
// Releases it synchronously and enables comparison one cycle later

module shadow_reset_gen #(
  parameter int LockstepOffset = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  localparam int CntW = $clog2(LockstepOffset);

  logic [CntW-1:0] cnt_q, cnt_d;
  logic            cnt_done;
  logic            rst_set_q;
  logic            cmp_en_q;

  // Counter parks at LockstepOffset-1
  assign cnt_done = (cnt_q == CntW'(LockstepOffset - 1));
  assign cnt_d    = cnt_done ? cnt_q : cnt_q + CntW'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      rst_set_q <= 1'b0;
      cmp_en_q  <= 1'b0;
    end else begin
      cnt_q     <= cnt_d;
      rst_set_q <= cnt_done;
      cmp_en_q  <= rst_set_q;
    end
  end

  assign shadow_rst_no = rst_set_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

//--- hdl/lockstep_compare.sv
// Compares the shadow unit's outputs against the main unit's outputs
// Main outputs are delayed LockstepOffset+1 cycles to line up with registered shadow outputs

module lockstep_compare import lockstep_pkg::*; #(
  parameter int LockstepOffset = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     cmp_en_i,
  input  logic     main_ack_i,
  input  wb_data_t main_dat_i,
  input  logic     shadow_ack_i,
  input  wb_data_t shadow_dat_i,
  output logic     alert_major_o
);

  // One extra stage for the shadow output register
  localparam int OutputsOffset = LockstepOffset + 1;
  localparam int Last          = OutputsOffset - 1;

  logic     [OutputsOffset-1:0] main_ack_q;
  wb_data_t [OutputsOffset-1:0] main_dat_q;
  logic                         shadow_ack_q;
  wb_data_t                     shadow_dat_q;
  logic                         mismatch;
  logic                         alert_q;

  ////////////////////
  // Output delays
  ////////////////////

  // Filled with reset values while the units are held in reset
  always_ff @(posedge clk_i) begin
    main_ack_q   <= {main_ack_q[OutputsOffset-2:0], main_ack_i};
    main_dat_q   <= {main_dat_q[OutputsOffset-2:0], main_dat_i};
    shadow_ack_q <= shadow_ack_i;
    shadow_dat_q <= shadow_dat_i;
  end

  ////////////////////
  // Compare
  ////////////////////

  assign mismatch = (main_ack_q[Last] != shadow_ack_q) |
                    (main_dat_q[Last] != shadow_dat_q);

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else if (cmp_en_i && mismatch) begin
      alert_q <= 1'b1;
    end
  end

  assign alert_major_o = alert_q;

endmodule

//--- hdl/lockstep_top.sv
// Dual-redundant Wishbone checksum peripheral with a delayed shadow copy
// The main unit serves the bus, the shadow replays it LockstepOffset cycles later
// Any divergence raises a sticky major alert

module lockstep_top import lockstep_pkg::*; #(
  parameter int LockstepOffset = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     wb_cyc_i,
  input  logic     wb_stb_i,
  input  logic     wb_we_i,
  input  wb_adr_t  wb_adr_i,
  input  wb_data_t wb_dat_i,
  input  logic     inject_fault_i,
  output wb_data_t wb_dat_o,
  output logic     wb_ack_o,
  output logic     alert_major_o
);

  // Shadow bus, delayed copy of the master
  logic     sh_cyc, sh_stb, sh_we;
  wb_adr_t  sh_adr;
  wb_data_t sh_dat_in;
  wb_data_t sh_dat_out;
  logic     sh_ack;

  logic     shadow_rst_n;
  logic     cmp_en;

  // Main unit drives the outside bus
  checksum_unit u_main (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  input_delay #(
    .LockstepOffset (LockstepOffset)
  ) u_input_delay (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .inject_fault_i (inject_fault_i),
    .dly_cyc_o      (sh_cyc),
    .dly_stb_o      (sh_stb),
    .dly_we_o       (sh_we),
    .dly_adr_o      (sh_adr),
    .dly_dat_o      (sh_dat_in)
  );

  shadow_reset_gen #(
    .LockstepOffset (LockstepOffset)
  ) u_shadow_reset_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  checksum_unit u_shadow (
    .clk_i    (clk_i),
    .rst_ni   (shadow_rst_n),
    .wb_cyc_i (sh_cyc),
    .wb_stb_i (sh_stb),
    .wb_we_i  (sh_we),
    .wb_adr_i (sh_adr),
    .wb_dat_i (sh_dat_in),
    .wb_dat_o (sh_dat_out),
    .wb_ack_o (sh_ack)
  );

  lockstep_compare #(
    .LockstepOffset (LockstepOffset)
  ) u_compare (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmp_en_i      (cmp_en),
    .main_ack_i    (wb_ack_o),
    .main_dat_i    (wb_dat_o),
    .shadow_ack_i  (sh_ack),
    .shadow_dat_i  (sh_dat_out),
    .alert_major_o (alert_major_o)
  );

endmodule

//--- testbench/tb_clock_gen.sv
// Clock and reset source for the lockstep testbench
// Reset is active low, held for ResetCycles rising edges, then released on an edge

module tb_clock_gen #(
  parameter int ClkPeriod   = 4,
  parameter int ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- testbench/tb_lockstep.sv
// Testbench for the lockstep checksum peripheral
// Drives Wishbone traffic, checks reads against a reference checksum, watches the alert

module tb_lockstep import lockstep_pkg::*; ();

  localparam int LockstepOffset = 2;
  localparam int AckTimeout     = 10;
  localparam int AlertTimeout   = 10;
  localparam int ResetTimeout   = 30;
  localparam int NumWrites      = 20;

  logic     clk, rst_n;
  logic     wb_cyc, wb_stb, wb_we, inject_fault;
  wb_adr_t  wb_adr;
  wb_data_t wb_dat_in, wb_dat_out;
  logic     wb_ack, alert_major;

  // Reference model state
  wb_data_t ref_sum;
  int       ref_count;
  bit       fault_injected;
  bit       alert_seen;

  // Expected read data, oldest first
  wb_data_t exp_q[$];
  string    name_q[$];
  wb_data_t exp_rdata;
  string    exp_name;

  tb_clock_gen #(.ClkPeriod(4), .ResetCycles(10)) u_clock_gen (.clk_o(clk), .rst_no(rst_n));

  lockstep_top #(.LockstepOffset(LockstepOffset)) dut_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .wb_cyc_i       (wb_cyc),
    .wb_stb_i       (wb_stb),
    .wb_we_i        (wb_we),
    .wb_adr_i       (wb_adr),
    .wb_dat_i       (wb_dat_in),
    .inject_fault_i (inject_fault),
    .wb_dat_o       (wb_dat_out),
    .wb_ack_o       (wb_ack),
    .alert_major_o  (alert_major)
  );

  // Rotate left by one, then XOR in the written word
  function automatic wb_data_t expected_checksum(wb_data_t sum, wb_data_t word);
    wb_data_t rotated;
    rotated = (sum << 1) | (sum >> 31);
    return rotated ^ word;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  ////////////////////
  // Bus tasks
  ////////////////////

  task automatic bus_access(input logic we, input wb_adr_t adr, input wb_data_t dat,
                            input logic inject, input string name);
    int cycles;
    bit got_ack;
    cycles  = 0;
    got_ack = 1'b0;
    @(posedge clk);
    wb_cyc       <= 1'b1;
    wb_stb       <= 1'b1;
    wb_we        <= we;
    wb_adr       <= adr;
    wb_dat_in    <= dat;
    inject_fault <= inject;
    // Cycle in which stb is first seen, no ack yet
    @(negedge clk);
    assert (!wb_ack) else
      stop_with_failure($sformatf("FAIL %s ack in stb cycle: expected 0, actual %0b",
                                  name, wb_ack));
    while (!got_ack) begin
      @(negedge clk);
      cycles++;
      if (wb_ack) begin
        got_ack = 1'b1;
      end else if (cycles >= AckTimeout) begin
        stop_with_failure($sformatf("wb_ack_o never arrived for access %s", name));
      end
    end
    assert (cycles == 1) else
      stop_with_failure($sformatf("FAIL %s ack latency: expected 1, actual %0d",
                                  name, cycles));
    @(posedge clk);
    wb_cyc       <= 1'b0;
    wb_stb       <= 1'b0;
    wb_we        <= 1'b0;
    inject_fault <= 1'b0;
    @(negedge clk);
    assert (!wb_ack) else
      stop_with_failure($sformatf("FAIL %s ack width: expected 0, actual %0b", name, wb_ack));
  endtask

  task automatic read_check(input wb_adr_t adr, input string name);
    wb_data_t expected;
    expected = (adr == AdrSum) ? ref_sum : wb_data_t'(ref_count & 32'h0000_ffff);
    exp_q.push_back(expected);
    name_q.push_back(name);
    bus_access(1'b0, adr, '0, 1'b0, name);
  endtask

  task automatic write_word(input wb_data_t word, input logic inject, input string name);
    bus_access(1'b1, AdrSum, word, inject, name);
    // Only the shadow sees the corrupted word
    ref_sum   = expected_checksum(ref_sum, word);
    ref_count = ref_count + 1;
  endtask

  task automatic clear_checksum(input string name);
    bus_access(1'b1, AdrCount, $urandom(), 1'b0, name);
    ref_sum   = '0;
    ref_count = 0;
  endtask

  task automatic wait_for_reset();
    int cycles;
    bit released;
    cycles   = 0;
    released = 1'b0;
    while (!released) begin
      @(negedge clk);
      cycles++;
      if (rst_n === 1'b1) begin
        released = 1'b1;
      end else if (cycles >= ResetTimeout) begin
        stop_with_failure("Reset was never released");
      end
    end
  endtask

  task automatic wait_for_alert();
    int cycles;
    cycles = 0;
    while (!alert_seen) begin
      @(negedge clk);
      cycles++;
      if (alert_major) begin
        alert_seen = 1'b1;
      end else if (cycles >= AlertTimeout) begin
        stop_with_failure("alert_major_o never rose after the injected fault");
      end
    end
  endtask

  ////////////////////
  // Compare process
  ////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      if (wb_ack && !wb_we) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("A read was acknowledged with no expected value queued");
        end else begin
          exp_rdata = exp_q.pop_front();
          exp_name  = name_q.pop_front();
          assert (wb_dat_out == exp_rdata) else
            stop_with_failure($sformatf("FAIL %s: expected %h, actual %h",
                                        exp_name, exp_rdata, wb_dat_out));
        end
      end
      if (!fault_injected) begin
        assert (!alert_major) else
          stop_with_failure("alert_major_o rose during fault-free traffic");
      end
      if (alert_seen) begin
        assert (alert_major) else stop_with_failure("alert_major_o fell after it was raised");
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = AdrSum;
    wb_dat_in      = '0;
    inject_fault   = 1'b0;
    ref_sum        = '0;
    ref_count      = 0;
    fault_injected = 1'b0;
    alert_seen     = 1'b0;
    void'($urandom(32'h6bc4_289c));

    wait_for_reset();
    // Let the shadow leave reset before traffic
    repeat (LockstepOffset + 2) @(posedge clk);
    @(negedge clk);
    assert (!wb_ack) else stop_with_failure("wb_ack_o is high after reset");
    assert (!alert_major) else stop_with_failure("alert_major_o is high after reset");
    read_check(AdrSum, "reset_sum");
    read_check(AdrCount, "reset_count");

    repeat (NumWrites) write_word($urandom(), 1'b0, "random_write");
    read_check(AdrSum, "random_sum");
    read_check(AdrCount, "random_count");

    clear_checksum("clear");
    read_check(AdrSum, "clear_sum");
    read_check(AdrCount, "clear_count");
    repeat (12) write_word($urandom(), 1'b0, "fresh_write");
    read_check(AdrSum, "fresh_sum");
    read_check(AdrCount, "fresh_count");

    // Corrupt the shadow's copy of one write
    fault_injected = 1'b1;
    write_word($urandom(), 1'b1, "inject_write");
    wait_for_alert();
    read_check(AdrSum, "inject_sum");
    write_word($urandom(), 1'b0, "post_fault_write");
    read_check(AdrSum, "post_fault_sum");
    read_check(AdrCount, "post_fault_count");

    repeat (2) @(negedge clk);
    assert (exp_q.size() == 0) else
      stop_with_failure("Some expected reads were never acknowledged");
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- build.f
hdl/lockstep_pkg.sv
hdl/checksum_unit.sv
hdl/input_delay.sv
hdl/shadow_reset_gen.sv
hdl/lockstep_compare.sv
hdl/lockstep_top.sv
testbench/tb_clock_gen.sv
testbench/tb_lockstep.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_lockstep -o sim_lockstep

out=$(./obj_dir/sim_lockstep 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^TEST PASS$"; then
  exit 0
else
  exit 1
fi
